/* verilog.f */
+incdir+test
rtl/texmap_pkg.sv
rtl/texmap_regs.sv
rtl/raster_scan.sv
rtl/plane_eval.sv
rtl/polygon_select.sv
rtl/texel_shader.sv
rtl/texmap_top.sv
test/tb_texmap.sv

/* Bender.yml */
package:
  name: texmap

sources:
  - rtl/texmap_pkg.sv
  - rtl/texmap_regs.sv
  - rtl/raster_scan.sv
  - rtl/plane_eval.sv
  - rtl/polygon_select.sv
  - rtl/texel_shader.sv
  - rtl/texmap_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_texmap.sv

/* test/tb_texmap_model.svh */
// testbench model: random source and expected pixel colour of the texture pipeline
`ifndef TB_TEXMAP_MODEL_SVH
`define TB_TEXMAP_MODEL_SVH

// 32-bit LCG, upper bits are the useful ones
function automatic logic [31:0] lcg_next(inout logic [31:0] state);
	state = state * 32'd1664525 + 32'd1013904223;
	return state;
endfunction

// a*x + b*y + c of plane q, 32-bit wrap like the hardware
function automatic int plane_at(input int q, input int x, input int y, input int bank);
	if (bank != 0)
		return coef_frm[3*q] * x + coef_frm[3*q + 1] * y + coef_frm[3*q + 2];
	return coef_live[3*q] * x + coef_live[3*q + 1] * y + coef_live[3*q + 2];
endfunction

// first polygon with all edges >= 0 picks the texel, else background
function automatic logic [23:0] model_color(input int x, input int y, input int bank);
	int         u;
	int         v;
	logic [7:0] idx;
	for (int p = 0; p < POLY; p++) begin
		if (plane_at(5*p, x, y, bank) >= 0 && plane_at(5*p + 1, x, y, bank) >= 0 &&
				plane_at(5*p + 2, x, y, bank) >= 0) begin
			u   = plane_at(5*p + 3, x, y, bank);
			v   = plane_at(5*p + 4, x, y, bank);
			idx = {v[11:8], u[11:8]};	// integer part, wraps at 16
			return tex_m[idx];
		end
	end
	return (bank != 0) ? frm_bgc : reg_m[3][23:0];
endfunction

`endif

/* test/tb_texmap.sv */
// testbench for the texture-mapping pixel pipeline
`timescale 1ns/1ps

module tb_texmap;

	localparam int POLY   = 2;
	localparam int WORDS  = POLY * 5 * 3;
	localparam int W      = 16;
	localparam int H      = 8;
	localparam int FRAMES = 4;
	// about 700 setup cycles plus 4 frames of 128 beats at 3/4 ready, tripled
	localparam int MAX_CYCLES = 5000;

	logic        clk;
	logic        rst_n_i;
	logic [9:0]  wb_adr_i;
	logic [31:0] wb_dat_i;
	logic        wb_we_i;
	logic [3:0]  wb_sel_i;
	logic        wb_stb_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	logic        m_axi4s_tready_i;
	logic [23:0] m_axi4s_tdata_o;
	logic        m_axi4s_tuser_o;
	logic        m_axi4s_tlast_o;
	logic        m_axi4s_tvalid_o;

	int          coef_live [WORDS];	// as last written
	int          coef_frm  [WORDS];	// taken at each frame start
	logic [31:0] reg_m     [4];
	logic [23:0] frm_bgc;
	logic [23:0] tex_m     [256];
	logic [23:0] ref_beat  [W*H];	// frame 0, full rate
	logic [31:0] rd_exp;
	logic [31:0] seed_stim;
	logic [31:0] seed_rdy;
	logic        rand_ready;
	int          bx;
	int          by;
	int          frames_done;
	int          starts;
	int          cycles;
	int          err_stream;
	int          err_bus;

	`include "tb_texmap_model.svh"

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	texmap_top #(
		.POLYGON_NUM (POLY)
	) u_dut (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.wb_adr_i         (wb_adr_i),
		.wb_dat_i         (wb_dat_i),
		.wb_we_i          (wb_we_i),
		.wb_sel_i         (wb_sel_i),
		.wb_stb_i         (wb_stb_i),
		.wb_dat_o         (wb_dat_o),
		.wb_ack_o         (wb_ack_o),
		.m_axi4s_tready_i (m_axi4s_tready_i),
		.m_axi4s_tdata_o  (m_axi4s_tdata_o),
		.m_axi4s_tuser_o  (m_axi4s_tuser_o),
		.m_axi4s_tlast_o  (m_axi4s_tlast_o),
		.m_axi4s_tvalid_o (m_axi4s_tvalid_o)
	);

	function automatic logic [31:0] reg_mask(input int adr);
		case (adr)
			0:       return 32'h0000_0001;
			1, 2:    return 32'h0000_03FF;
			3:       return 32'h00FF_FFFF;
			default: return 32'hFFFF_FFFF;
		endcase
	endfunction

	function automatic int rnd_step();
		return int'((lcg_next(seed_stim) >> 16) & 32'h1FF) - 256;	// about one texel
	endfunction

	// ------------------------------------------------------------
	//  bus access
	// ------------------------------------------------------------
	task automatic bus_write(input int adr, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] lanes;
		for (int i = 0; i < 4; i++)
			lanes[8*i +: 8] = {8{sel[i]}};
		@(posedge clk);
		#1;
		wb_adr_i = 10'(adr);
		wb_dat_i = dat;
		wb_sel_i = sel;
		wb_we_i  = 1'b1;
		wb_stb_i = 1'b1;
		@(posedge clk);
		#1;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		if (adr >= 512)
			tex_m[adr[7:0]] = dat[23:0];
		else if (adr < 4)
			reg_m[adr] = ((reg_m[adr] & ~lanes) | (dat & lanes)) & reg_mask(adr);
		else if (adr >= 8 && adr < 8 + WORDS)
			coef_live[adr-8] = (coef_live[adr-8] & ~lanes) | (dat & lanes);
	endtask

	task automatic bus_read(input int adr);
		@(posedge clk);
		#1;
		rd_exp = '0;	// texture space and holes
		if (adr < 4)
			rd_exp = reg_m[adr];
		else if (adr >= 8 && adr < 8 + WORDS)
			rd_exp = coef_live[adr-8];
		wb_adr_i = 10'(adr);
		wb_sel_i = 4'hF;
		wb_we_i  = 1'b0;
		wb_stb_i = 1'b1;
		@(posedge clk);
		#1;
		wb_stb_i = 1'b0;
	endtask

	task automatic write_readback(input int adr, input logic [31:0] dat, input logic [3:0] sel);
		bus_write(adr, dat, sel);
		bus_read(adr);
	endtask

	task automatic set_plane(input int q, input int a, input int b, input int c);
		write_readback(8 + 3*q, a, 4'hF);
		write_readback(8 + 3*q + 1, b, 4'hF);
		write_readback(8 + 3*q + 2, c, 4'hF);
	endtask

	task automatic set_tex_plane(input int q);
		set_plane(q, rnd_step(), rnd_step(), int'(lcg_next(seed_stim)));
	endtask

	initial begin
		wb_adr_i         = '0;
		wb_dat_i         = '0;
		wb_we_i          = 1'b0;
		wb_sel_i         = '0;
		wb_stb_i         = 1'b0;
		m_axi4s_tready_i = 1'b1;
		rand_ready       = 1'b0;
		rd_exp           = '0;
		seed_stim        = 32'd51;
		seed_rdy         = 32'd51;
		err_stream       = 0;
		err_bus          = 0;
		for (int i = 0; i < 4; i++)
			reg_m[i] = '0;
		for (int i = 0; i < WORDS; i++)
			coef_live[i] = 0;
		rst_n_i = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n_i = 1'b1;

		// byte lanes on registers
		write_readback(1, 32'hFFFF_FFFF, 4'hF);
		write_readback(1, 32'h0000_0012, 4'b0001);
		write_readback(3, 32'h00A1_B2C3, 4'hF);
		write_readback(3, 32'h5566_7788, 4'b0010);
		write_readback(3, 32'h5566_7788, 4'b0101);
		write_readback(8, 32'hDEAD_BEEF, 4'hF);
		write_readback(8, 32'h1234_5678, 4'b1001);
		bus_read(512 + 7);
		bus_read(5);

		for (int i = 0; i < 256; i++)
			bus_write(512 + i, lcg_next(seed_stim), 4'hF);

		// polygon 0: x >= 2, y >= 1, x + y <= 13
		set_plane(0, 1, 0, -2);
		set_plane(1, 0, 1, -1);
		set_plane(2, -1, -1, 13);
		set_tex_plane(3);
		set_tex_plane(4);
		// polygon 1: x <= 14, y <= 6, x + y >= 8, overlaps polygon 0
		set_plane(5, -1, 0, 14);
		set_plane(6, 0, -1, 6);
		set_plane(7, 1, 1, -8);
		set_tex_plane(8);
		set_tex_plane(9);
		write_readback(1, W - 1, 4'hF);
		write_readback(2, H - 1, 4'hF);
		write_readback(3, lcg_next(seed_stim), 4'hF);
		write_readback(0, 1, 4'hF);

		wait (frames_done == 1);
		rand_ready = 1'b1;
		wait (starts == 2);
		// mid-frame rewrite, due with frame 2
		write_readback(3, lcg_next(seed_stim), 4'hF);
		set_tex_plane(3);
		set_plane(7, 1, 1, -4);
		wait (starts == FRAMES);
		write_readback(0, 0, 4'hF);
		wait (frames_done == FRAMES);
		repeat (60) @(posedge clk);	// stream must stay quiet

		$display("errors: stream %0d, bus %0d", err_stream, err_bus);
		if (err_stream + err_bus == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// ready at about 3 in 4 cycles once back-pressure is on
	always @(posedge clk) begin
		#1;
		if (rand_ready)
			m_axi4s_tready_i = (lcg_next(seed_rdy) >> 16) % 4 != 0;
		else
			m_axi4s_tready_i = 1'b1;
	end

	always @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
			if (cycles >= MAX_CYCLES) begin
				$display("timeout: run still busy after %0d cycles", MAX_CYCLES);
				$display("ERRORS FOUND");
				$finish;
			end
		end
	end

	// ------------------------------------------------------------
	//  beat monitor
	// ------------------------------------------------------------
	always @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bx          <= 0;
			by          <= 0;
			frames_done <= 0;
			starts      <= 0;
		end else if (m_axi4s_tvalid_o && m_axi4s_tready_i) begin
			if (bx == 0 && by == 0) begin
				starts  <= starts + 1;
				frm_bgc <= reg_m[3][23:0];
				for (int i = 0; i < WORDS; i++)
					coef_frm[i] <= coef_live[i];
			end
			if (frames_done == 0)
				ref_beat[by*W + bx] <= m_axi4s_tdata_o;
			if (bx == W - 1) begin
				bx <= 0;
				by <= (by == H - 1) ? 0 : by + 1;
				if (by == H - 1)
					frames_done <= frames_done + 1;
			end else begin
				bx <= bx + 1;
			end
		end
	end

	// first beat of a frame checks against the new values
	a_pixel: assert property (@(posedge clk) disable iff (!rst_n_i)
		(m_axi4s_tvalid_o && m_axi4s_tready_i) |->
		(m_axi4s_tdata_o == model_color(bx, by, int'(bx != 0 || by != 0))))
		else begin
			err_stream++;
			$display("FAIL %0t m_axi4s_tdata_o expected %h actual %h", $time,
				model_color($sampled(bx), $sampled(by),
				int'($sampled(bx) != 0 || $sampled(by) != 0)), $sampled(m_axi4s_tdata_o));
		end

	a_user: assert property (@(posedge clk) disable iff (!rst_n_i)
		(m_axi4s_tvalid_o && m_axi4s_tready_i) |-> (m_axi4s_tuser_o == (bx == 0 && by == 0)))
		else begin
			err_stream++;
			$display("FAIL %0t m_axi4s_tuser_o expected %0b actual %0b", $time,
				$sampled(bx) == 0 && $sampled(by) == 0, $sampled(m_axi4s_tuser_o));
		end

	a_last: assert property (@(posedge clk) disable iff (!rst_n_i)
		(m_axi4s_tvalid_o && m_axi4s_tready_i) |-> (m_axi4s_tlast_o == (bx == W - 1)))
		else begin
			err_stream++;
			$display("FAIL %0t m_axi4s_tlast_o expected %0b actual %0b", $time,
				$sampled(bx) == W - 1, $sampled(m_axi4s_tlast_o));
		end

	// frame 1 has random ready and the same parameters as frame 0
	a_repeat: assert property (@(posedge clk) disable iff (!rst_n_i)
		(m_axi4s_tvalid_o && m_axi4s_tready_i && frames_done == 1) |->
		(m_axi4s_tdata_o == ref_beat[by*W + bx]))
		else begin
			err_stream++;
			$display("FAIL %0t m_axi4s_tdata_o expected %h actual %h", $time,
				ref_beat[$sampled(by)*W + $sampled(bx)], $sampled(m_axi4s_tdata_o));
		end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(m_axi4s_tvalid_o && !m_axi4s_tready_i) |=>
		(m_axi4s_tvalid_o && $stable(m_axi4s_tdata_o) &&
		$stable(m_axi4s_tuser_o) && $stable(m_axi4s_tlast_o)))
		else begin
			err_stream++;
			$display("stream beat changed or dropped while stalled at %0t", $time);
		end

	a_stop: assert property (@(posedge clk) disable iff (!rst_n_i)
		(frames_done == FRAMES) |-> !m_axi4s_tvalid_o)
		else begin
			err_stream++;
			$display("stream kept running after enable was cleared, at %0t", $time);
		end

	a_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_stb_i |-> wb_ack_o)
		else begin
			err_bus++;
			$display("bus access not acknowledged in its strobe cycle at %0t", $time);
		end

	a_read: assert property (@(posedge clk) disable iff (!rst_n_i)
		(wb_stb_i && !wb_we_i) |-> (wb_dat_o == rd_exp))
		else begin
			err_bus++;
			$display("FAIL %0t wb_dat_o expected %h actual %h", $time,
				$sampled(rd_exp), $sampled(wb_dat_o));
		end

endmodule

/* rtl/texmap_top.sv */
// texture-mapping pixel pipeline top: registers, scanner, evaluators, selector, shader
`timescale 1ns/1ps

module texmap_top
	import texmap_pkg::*;
#(
	parameter int POLYGON_NUM = 2
) (
	input  logic       clk,
	input  logic       rst_n_i,
	input  wb_adr_t    wb_adr_i,
	input  wb_dat_t    wb_dat_i,
	input  logic       wb_we_i,
	input  logic [3:0] wb_sel_i,
	input  logic       wb_stb_i,
	output wb_dat_t    wb_dat_o,
	output logic       wb_ack_o,
	input  logic       m_axi4s_tready_i,
	output color_t     m_axi4s_tdata_o,
	output logic       m_axi4s_tuser_o,
	output logic       m_axi4s_tlast_o,
	output logic       m_axi4s_tvalid_o
);

	localparam int COEF_NUM = POLYGON_NUM * PLANE_PER_POLY;

	logic        cke;
	logic        enable;
	coord_x_t    width_m1;
	coord_y_t    height_m1;
	color_t      bgc;
	plane_coef_t coef  [COEF_NUM];
	plane_t      plane [COEF_NUM];
	logic        tex_we;
	texel_addr_t tex_addr;
	color_t      tex_data;
	logic        frame_latch;
	logic        frame_prime;
	logic        step;
	logic        first_px;
	logic        last_in_line;
	frag_t       frag;

	texmap_regs #(
		.POLYGON_NUM (POLYGON_NUM)
	) u_regs (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_we_i       (wb_we_i),
		.wb_sel_i      (wb_sel_i),
		.wb_stb_i      (wb_stb_i),
		.frame_latch_i (frame_latch),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.enable_o      (enable),
		.width_m1_o    (width_m1),
		.height_m1_o   (height_m1),
		.bgc_o         (bgc),
		.coef_o        (coef),
		.tex_we_o      (tex_we),
		.tex_addr_o    (tex_addr),
		.tex_data_o    (tex_data)
	);

	raster_scan u_scan (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.enable_i       (enable),
		.cke_i          (cke),
		.width_m1_i     (width_m1),
		.height_m1_i    (height_m1),
		.frame_latch_o  (frame_latch),
		.frame_prime_o  (frame_prime),
		.step_o         (step),
		.first_px_o     (first_px),
		.last_in_line_o (last_in_line)
	);

	// ----------------------------------------------------------
	//  one evaluator per plane, polygon-major
	// ----------------------------------------------------------
	for (genvar i = 0; i < COEF_NUM; i++) begin : g_plane
		plane_eval u_plane (
			.clk           (clk),
			.rst_n_i       (rst_n_i),
			.coef_i        (coef[i]),
			.frame_prime_i (frame_prime),
			.step_i        (step),
			.line_end_i    (last_in_line),
			.value_o       (plane[i])
		);
	end

	polygon_select #(
		.POLYGON_NUM (POLYGON_NUM)
	) u_select (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.step_i         (step),
		.first_px_i     (first_px),
		.last_in_line_i (last_in_line),
		.plane_i        (plane),
		.frag_o         (frag)
	);

	texel_shader u_shader (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.frag_i           (frag),
		.bgc_i            (bgc),
		.tex_we_i         (tex_we),
		.tex_addr_i       (tex_addr),
		.tex_data_i       (tex_data),
		.m_axi4s_tready_i (m_axi4s_tready_i),
		.cke_o            (cke),
		.m_axi4s_tdata_o  (m_axi4s_tdata_o),
		.m_axi4s_tuser_o  (m_axi4s_tuser_o),
		.m_axi4s_tlast_o  (m_axi4s_tlast_o),
		.m_axi4s_tvalid_o (m_axi4s_tvalid_o)
	);

endmodule

/* rtl/texel_shader.sv */
// pixel shader: texture RAM lookup, background fill and video stream output
`timescale 1ns/1ps

module texel_shader
	import texmap_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n_i,
	input  frag_t       frag_i,
	input  color_t      bgc_i,
	input  logic        tex_we_i,
	input  texel_addr_t tex_addr_i,
	input  color_t      tex_data_i,
	input  logic        m_axi4s_tready_i,
	output logic        cke_o,
	output color_t      m_axi4s_tdata_o,
	output logic        m_axi4s_tuser_o,
	output logic        m_axi4s_tlast_o,
	output logic        m_axi4s_tvalid_o
);

	localparam int TEX_DEPTH = 2 ** (2 * TEX_SIZE_LOG2);

	color_t      tex_mem [TEX_DEPTH];
	texel_addr_t rd_addr;
	logic        cke;
	logic        seen_phase;
	logic        s3_valid;
	logic        s3_frame_start;
	logic        s3_line_end;
	logic        s3_hit;
	color_t      s3_texel;
	color_t      s3_bgc;

	assign cke   = m_axi4s_tready_i || !m_axi4s_tvalid_o;
	assign cke_o = cke;

	// integer parts of v and u, wrap comes from dropping upper bits
	assign rd_addr = {frag_i.v[TEX_FRAC +: TEX_SIZE_LOG2], frag_i.u[TEX_FRAC +: TEX_SIZE_LOG2]};

	always_ff @(posedge clk) begin
		if (tex_we_i)
			tex_mem[tex_addr_i] <= tex_data_i;
	end

	// ----------------------------------------------------------
	//  texture read stage
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			seen_phase     <= 1'b0;
			s3_valid       <= 1'b0;
			s3_frame_start <= 1'b0;
			s3_line_end    <= 1'b0;
			s3_hit         <= 1'b0;
		end else if (cke) begin
			s3_valid       <= (frag_i.phase != seen_phase);	// new fragment arrived
			seen_phase     <= frag_i.phase;
			s3_frame_start <= frag_i.frame_start;
			s3_line_end    <= frag_i.line_end;
			s3_hit         <= frag_i.hit;
		end
	end

	always_ff @(posedge clk) begin
		if (cke) begin
			s3_texel <= tex_mem[rd_addr];
			s3_bgc   <= bgc_i;	// keeps the frame's own background
		end
	end

	// ----------------------------------------------------------
	//  output register
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			m_axi4s_tvalid_o <= 1'b0;
			m_axi4s_tuser_o  <= 1'b0;
			m_axi4s_tlast_o  <= 1'b0;
		end else if (cke) begin
			m_axi4s_tvalid_o <= s3_valid;
			m_axi4s_tuser_o  <= s3_frame_start;
			m_axi4s_tlast_o  <= s3_line_end;
		end
	end

	always_ff @(posedge clk) begin
		if (cke)
			m_axi4s_tdata_o <= s3_hit ? s3_texel : s3_bgc;
	end

	// a fragment produced during a stall would be skipped by the read stage
	a_frag_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		!cke |=> $stable(frag_i.phase))
		else $error("new fragment arrived while stalled");

endmodule

/* rtl/polygon_select.sv */
// coverage test per polygon, lowest index wins, fragment registered on step
`timescale 1ns/1ps

module polygon_select
	import texmap_pkg::*;
#(
	parameter int POLYGON_NUM = 2
) (
	input  logic   clk,
	input  logic   rst_n_i,
	input  logic   step_i,
	input  logic   first_px_i,
	input  logic   last_in_line_i,
	input  plane_t plane_i [POLYGON_NUM*PLANE_PER_POLY],
	output frag_t  frag_o
);

	logic   hit;
	plane_t u;
	plane_t v;

	// walk from the top so the lowest covering index is kept
	always_comb begin
		logic covered;
		hit = 1'b0;
		u   = '0;
		v   = '0;
		for (int p = POLYGON_NUM - 1; p >= 0; p--) begin
			covered = 1'b1;
			for (int e = 0; e < EDGE_NUM; e++) begin
				if (plane_i[p*PLANE_PER_POLY + e] < 0)
					covered = 1'b0;	// outside this edge
			end
			if (covered) begin
				hit = 1'b1;
				u   = plane_i[p*PLANE_PER_POLY + EDGE_NUM];
				v   = plane_i[p*PLANE_PER_POLY + EDGE_NUM + 1];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			frag_o <= '0;
		end else if (step_i) begin
			frag_o.phase       <= ~frag_o.phase;
			frag_o.frame_start <= first_px_i;
			frag_o.line_end    <= last_in_line_i;
			frag_o.hit         <= hit;
			frag_o.u           <= u;
			frag_o.v           <= v;
		end
	end

endmodule

/* rtl/plane_eval.sv */
// incremental evaluator of one linear equation a*x + b*y + c over the raster
`timescale 1ns/1ps

module plane_eval
	import texmap_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n_i,
	input  plane_coef_t coef_i,
	input  logic        frame_prime_i,
	input  logic        step_i,
	input  logic        line_end_i,
	output plane_t      value_o
);

	plane_t value;
	plane_t line_base;	// value at x = 0 of the current line
	plane_t next_base;

	assign next_base = line_base + coef_i.b;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			value     <= '0;
			line_base <= '0;
		end else if (frame_prime_i) begin
			value     <= coef_i.c;
			line_base <= coef_i.c;
		end else if (step_i) begin
			if (line_end_i) begin
				value     <= next_base;
				line_base <= next_base;
			end else begin
				value <= value + coef_i.a;
			end
		end
	end

	assign value_o = value;

endmodule

/* rtl/raster_scan.sv */
// raster scanner: frame FSM with x/y counters, stalled by cke
`timescale 1ns/1ps

module raster_scan
	import texmap_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     enable_i,
	input  logic     cke_i,
	input  coord_x_t width_m1_i,
	input  coord_y_t height_m1_i,
	output logic     frame_latch_o,
	output logic     frame_prime_o,
	output logic     step_o,
	output logic     first_px_o,
	output logic     last_in_line_o
);

	typedef enum logic [1:0] {IDLE, LATCH, PRIME, RUN} state_t;

	state_t   state;
	coord_x_t x;
	coord_y_t y;
	logic     last_px;

	assign last_in_line_o = (x == width_m1_i);
	assign last_px        = last_in_line_o && (y == height_m1_i);
	assign first_px_o     = (x == '0) && (y == '0);

	assign frame_latch_o = (state == LATCH) && cke_i;
	assign frame_prime_o = (state == PRIME) && cke_i;
	assign step_o        = (state == RUN) && cke_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= IDLE;
			x     <= '0;
			y     <= '0;
		end else if (cke_i) begin
			case (state)
				IDLE: if (enable_i) state <= LATCH;
				LATCH: state <= PRIME;
				PRIME: begin
					state <= RUN;
					x     <= '0;
					y     <= '0;
				end
				RUN: begin
					if (last_in_line_o) begin
						x <= '0;
						y <= y + 1'b1;
					end else begin
						x <= x + 1'b1;
					end
					if (last_px)
						state <= enable_i ? LATCH : IDLE;	// next frame or stop
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_x_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		(state == RUN) |-> (x <= width_m1_i))
		else $error("x beyond programmed width");

endmodule

/* rtl/texmap_regs.sv */
// register bank: bus decode, live and frame-start shadow parameters, texel writes
`timescale 1ns/1ps

module texmap_regs
	import texmap_pkg::*;
#(
	parameter int POLYGON_NUM = 2
) (
	input  logic        clk,
	input  logic        rst_n_i,
	input  wb_adr_t     wb_adr_i,
	input  wb_dat_t     wb_dat_i,
	input  logic        wb_we_i,
	input  logic [3:0]  wb_sel_i,
	input  logic        wb_stb_i,
	input  logic        frame_latch_i,
	output wb_dat_t     wb_dat_o,
	output logic        wb_ack_o,
	output logic        enable_o,
	output coord_x_t    width_m1_o,
	output coord_y_t    height_m1_o,
	output color_t      bgc_o,
	output plane_coef_t coef_o [POLYGON_NUM*PLANE_PER_POLY],
	output logic        tex_we_o,
	output texel_addr_t tex_addr_o,
	output color_t      tex_data_o
);

	localparam int COEF_NUM = POLYGON_NUM * PLANE_PER_POLY;
	localparam int WORD_NUM = COEF_NUM * 3;

	logic     reg_sel;
	logic     reg_we;
	wb_dat_t  lane_mask;
	logic     enable_r;
	coord_x_t width_r;
	coord_y_t height_r;
	color_t   bgc_r;
	plane_t   coef_live   [WORD_NUM];
	plane_t   coef_shadow [WORD_NUM];

	function automatic wb_dat_t merge(wb_dat_t old_val, wb_dat_t new_val, wb_dat_t mask);
		return (old_val & ~mask) | (new_val & mask);
	endfunction

	assign reg_sel  = !wb_adr_i[TEX_SEL_BIT];
	assign reg_we   = wb_stb_i && wb_we_i && reg_sel;
	assign wb_ack_o = wb_stb_i;	// always ready

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			lane_mask[8*i +: 8] = {8{wb_sel_i[i]}};
		end
	end

	// ----------------------------------------------------------
	//  control registers and their shadows
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			enable_r    <= 1'b0;
			width_r     <= '0;
			height_r    <= '0;
			bgc_r       <= '0;
			width_m1_o  <= '0;
			height_m1_o <= '0;
			bgc_o       <= '0;
		end else begin
			if (reg_we) begin
				case (wb_adr_i)
					REG_CTL:       enable_r <= 1'(merge(wb_dat_t'(enable_r), wb_dat_i, lane_mask));
					REG_WIDTH_M1:  width_r  <= coord_x_t'(merge(wb_dat_t'(width_r), wb_dat_i, lane_mask));
					REG_HEIGHT_M1: height_r <= coord_y_t'(merge(wb_dat_t'(height_r), wb_dat_i, lane_mask));
					REG_BGC:       bgc_r    <= color_t'(merge(wb_dat_t'(bgc_r), wb_dat_i, lane_mask));
					default:       ;
				endcase
			end
			if (frame_latch_i) begin
				width_m1_o  <= width_r;
				height_m1_o <= height_r;
				bgc_o       <= bgc_r;
			end
		end
	end

	// coefficient words, a/b/c per plane
	always_ff @(posedge clk) begin
		for (int i = 0; i < WORD_NUM; i++) begin
			if (reg_we && wb_adr_i == wb_adr_t'(REG_COEF_BASE + i))
				coef_live[i] <= merge(coef_live[i], wb_dat_i, lane_mask);
			if (frame_latch_i)
				coef_shadow[i] <= coef_live[i];
		end
	end

	always_comb begin
		for (int p = 0; p < COEF_NUM; p++) begin
			coef_o[p].a = coef_shadow[3*p];
			coef_o[p].b = coef_shadow[3*p + 1];
			coef_o[p].c = coef_shadow[3*p + 2];
		end
	end

	// read back live values, texture space reads as zero
	always_comb begin
		wb_dat_o = '0;
		if (reg_sel) begin
			case (wb_adr_i)
				REG_CTL:       wb_dat_o = wb_dat_t'(enable_r);
				REG_WIDTH_M1:  wb_dat_o = wb_dat_t'(width_r);
				REG_HEIGHT_M1: wb_dat_o = wb_dat_t'(height_r);
				REG_BGC:       wb_dat_o = wb_dat_t'(bgc_r);
				default: begin
					for (int i = 0; i < WORD_NUM; i++) begin
						if (wb_adr_i == wb_adr_t'(REG_COEF_BASE + i))
							wb_dat_o = coef_live[i];
					end
				end
			endcase
		end
	end

	assign enable_o   = enable_r;
	assign tex_we_o   = wb_stb_i && wb_we_i && !reg_sel;
	assign tex_addr_o = texel_addr_t'(wb_adr_i);
	assign tex_data_o = color_t'(wb_dat_i);

	a_sel_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
		(wb_stb_i && wb_we_i) |-> (wb_sel_i != '0))
		else $error("write with no byte lane selected");

endmodule

/* rtl/texmap_pkg.sv */
// texture-mapping pixel pipeline: shared widths, types and register map
package texmap_pkg;

	localparam int X_WIDTH = 10;
	localparam int Y_WIDTH = 10;

	typedef logic [X_WIDTH-1:0] coord_x_t;
	typedef logic [Y_WIDTH-1:0] coord_y_t;

	localparam int EDGE_NUM       = 3;
	localparam int PLANE_PER_POLY = 5;	// edges, then u, then v

	typedef logic signed [31:0] plane_t;

	typedef struct packed {
		plane_t a;	// x step
		plane_t b;	// y step
		plane_t c;	// value at origin
	} plane_coef_t;

	localparam int TEX_FRAC      = 8;
	localparam int TEX_SIZE_LOG2 = 4;

	typedef logic [2*TEX_SIZE_LOG2-1:0] texel_addr_t;	// {v, u}
	typedef logic [23:0]                color_t;
	typedef logic [9:0]                 wb_adr_t;
	typedef logic [31:0]                wb_dat_t;

	// register map, word addresses
	localparam wb_adr_t REG_CTL       = wb_adr_t'(0);
	localparam wb_adr_t REG_WIDTH_M1  = wb_adr_t'(1);
	localparam wb_adr_t REG_HEIGHT_M1 = wb_adr_t'(2);
	localparam wb_adr_t REG_BGC       = wb_adr_t'(3);
	localparam wb_adr_t REG_COEF_BASE = wb_adr_t'(8);
	localparam int      TEX_SEL_BIT   = 9;

	typedef struct packed {
		logic   phase;	// flips with every new fragment
		logic   frame_start;
		logic   line_end;
		logic   hit;
		plane_t u;
		plane_t v;
	} frag_t;

endpackage
